//--- rtl/axi_2x2.sv
`default_nettype none

module axi_2x2 (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     switch,
  output sram_pkg::bank_t         sel,

  // producer, write only
  input  wire axi_pkg::axi_addr_t awaddr,
  input  wire                     awvalid,
  output logic                    awready,
  input  wire axi_pkg::axi_data_t wdata,
  input  wire                     wvalid,
  output logic                    wready,
  output logic                    bvalid,
  input  wire                     bready,

  // consumer, read only
  input  wire axi_pkg::axi_addr_t araddr,
  input  wire                     arvalid,
  output logic                    arready,
  output axi_pkg::axi_data_t      rdata,
  output logic                    rvalid,
  input  wire                     rready,

  // controller 0
  output axi_pkg::axi_addr_t      out0_awaddr,
  output logic                    out0_awvalid,
  input  wire                     out0_awready,
  output axi_pkg::axi_data_t      out0_wdata,
  output logic                    out0_wvalid,
  input  wire                     out0_wready,
  input  wire                     out0_bvalid,
  output logic                    out0_bready,
  output axi_pkg::axi_addr_t      out0_araddr,
  output logic                    out0_arvalid,
  input  wire                     out0_arready,
  input  wire axi_pkg::axi_data_t out0_rdata,
  input  wire                     out0_rvalid,
  output logic                    out0_rready,

  // controller 1
  output axi_pkg::axi_addr_t      out1_awaddr,
  output logic                    out1_awvalid,
  input  wire                     out1_awready,
  output axi_pkg::axi_data_t      out1_wdata,
  output logic                    out1_wvalid,
  input  wire                     out1_wready,
  input  wire                     out1_bvalid,
  output logic                    out1_bready,
  output axi_pkg::axi_addr_t      out1_araddr,
  output logic                    out1_arvalid,
  input  wire                     out1_arready,
  input  wire axi_pkg::axi_data_t out1_rdata,
  input  wire                     out1_rvalid,
  output logic                    out1_rready
);

  logic pending;
  logic wr_busy;
  logic rd_busy;
  logic aw_go;
  logic w_go;
  logic ar_go;
  logic swap_now;

  // a pending swap stops new requests, so the controllers never raise ready
  assign aw_go = awvalid && !pending;
  assign w_go  = wvalid && !pending;
  assign ar_go = arvalid && !pending;

  // payload goes to both sides, valids only to the owner
  assign out0_awaddr = awaddr;
  assign out1_awaddr = awaddr;
  assign out0_wdata  = wdata;
  assign out1_wdata  = wdata;
  assign out0_araddr = araddr;
  assign out1_araddr = araddr;

  // producer owns bank sel
  assign out0_awvalid = aw_go && (sel == 1'b0);
  assign out1_awvalid = aw_go && (sel == 1'b1);
  assign out0_wvalid  = w_go && (sel == 1'b0);
  assign out1_wvalid  = w_go && (sel == 1'b1);
  assign out0_bready  = bready && (sel == 1'b0);
  assign out1_bready  = bready && (sel == 1'b1);

  // consumer owns the other bank
  assign out0_arvalid = ar_go && (sel == 1'b1);
  assign out1_arvalid = ar_go && (sel == 1'b0);
  assign out0_rready  = rready && (sel == 1'b1);
  assign out1_rready  = rready && (sel == 1'b0);

  assign awready = sel ? out1_awready : out0_awready;
  assign wready  = sel ? out1_wready : out0_wready;
  assign bvalid  = sel ? out1_bvalid : out0_bvalid;
  assign arready = sel ? out0_arready : out1_arready;
  assign rdata   = sel ? out0_rdata : out1_rdata;
  assign rvalid  = sel ? out0_rvalid : out1_rvalid;

  // swap only once both ports have drained
  assign swap_now = pending && !wr_busy && !rd_busy;

  always_ff @(posedge clk) begin
    if (reset) begin
      sel     <= '0;
      pending <= 1'b0;
      wr_busy <= 1'b0;
      rd_busy <= 1'b0;
    end else begin
      if (swap_now) begin
        sel     <= ~sel;
        pending <= 1'b0;
      end else if (switch) begin
        pending <= 1'b1;
      end

      // outstanding from request handshake to response handshake
      if (awvalid && awready) begin
        wr_busy <= 1'b1;
      end else if (bvalid && bready) begin
        wr_busy <= 1'b0;
      end

      if (arvalid && arready) begin
        rd_busy <= 1'b1;
      end else if (rvalid && rready) begin
        rd_busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // word address into one SRAM chip
  localparam int AXI_ADDR_WIDTH = 20;

  // one SRAM data word, always written whole
  localparam int AXI_DATA_WIDTH = 16;

  typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;
  typedef logic [AXI_DATA_WIDTH-1:0] axi_data_t;

endpackage

`default_nettype wire

//--- rtl/axi_sram_controller.sv
`default_nettype none

module axi_sram_controller (
  input  wire                     clk,
  input  wire                     reset,

  // write address and write data channels
  input  wire axi_pkg::axi_addr_t awaddr,
  input  wire                     awvalid,
  output logic                    awready,
  input  wire axi_pkg::axi_data_t wdata,
  input  wire                     wvalid,
  output logic                    wready,

  // write response
  output logic                    bvalid,
  input  wire                     bready,

  // read address and read data
  input  wire axi_pkg::axi_addr_t araddr,
  input  wire                     arvalid,
  output logic                    arready,
  output axi_pkg::axi_data_t      rdata,
  output logic                    rvalid,
  input  wire                     rready,

  // asynchronous SRAM pins
  output axi_pkg::axi_addr_t      sram_io_addr,
  inout  wire axi_pkg::axi_data_t sram_io_data,
  output logic                    sram_io_we_n,
  output logic                    sram_io_oe_n,
  output logic                    sram_io_ce_n
);

  sram_pkg::sram_state_e state;
  axi_pkg::axi_data_t    wdata_q;
  logic                  write_accept;
  logic                  read_accept;

  // writes win when both requests show up in the same cycle
  assign write_accept = (state == sram_pkg::IDLE) && awvalid && wvalid;
  assign read_accept  = (state == sram_pkg::IDLE) && arvalid && !write_accept;

  // aw and w are taken together
  assign awready = write_accept;
  assign wready  = write_accept;
  assign arready = read_accept;

  // responses are held until the master takes them
  assign bvalid = (state == sram_pkg::WRITE_RESP);
  assign rvalid = (state == sram_pkg::READ_RESP);

  // drive the data pins only during the write strobe
  assign sram_io_data = (state == sram_pkg::WRITE) ? wdata_q : 'z;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= sram_pkg::IDLE;
      sram_io_ce_n <= 1'b1;
      sram_io_we_n <= 1'b1;
      sram_io_oe_n <= 1'b1;
    end else begin
      case (state)
        sram_pkg::IDLE: begin
          if (write_accept) begin
            state        <= sram_pkg::WRITE;
            sram_io_ce_n <= 1'b0;
            sram_io_we_n <= 1'b0;
          end else if (read_accept) begin
            state        <= sram_pkg::READ;
            sram_io_ce_n <= 1'b0;
            sram_io_oe_n <= 1'b0;
          end
        end

        // one cycle with we_n low, then release
        sram_pkg::WRITE: begin
          state        <= sram_pkg::WRITE_RESP;
          sram_io_ce_n <= 1'b1;
          sram_io_we_n <= 1'b1;
        end

        sram_pkg::WRITE_RESP: begin
          if (bready) begin
            state <= sram_pkg::IDLE;
          end
        end

        // data pins are sampled as oe_n goes back high
        sram_pkg::READ: begin
          state        <= sram_pkg::READ_RESP;
          sram_io_ce_n <= 1'b1;
          sram_io_oe_n <= 1'b1;
        end

        sram_pkg::READ_RESP: begin
          if (rready) begin
            state <= sram_pkg::IDLE;
          end
        end

        default: begin
          state        <= sram_pkg::IDLE;
          sram_io_ce_n <= 1'b1;
          sram_io_we_n <= 1'b1;
          sram_io_oe_n <= 1'b1;
        end
      endcase
    end
  end

  // address and data captured at the handshake
  always_ff @(posedge clk) begin
    if (write_accept) begin
      sram_io_addr <= awaddr;
      wdata_q      <= wdata;
    end else if (read_accept) begin
      sram_io_addr <= araddr;
    end

    // read word stays put until rready
    if (state == sram_pkg::READ) begin
      rdata <= sram_io_data;
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi_sram_dbuf_controller.sv
`default_nettype none

module axi_sram_dbuf_controller (
  input  wire                     clk,
  input  wire                     reset,

  // swap producer and consumer banks
  input  wire                     switch,
  output wire sram_pkg::bank_t    prod_bank,

  // producer
  input  wire axi_pkg::axi_addr_t prod_axi_awaddr,
  input  wire                     prod_axi_awvalid,
  output wire                     prod_axi_awready,
  input  wire axi_pkg::axi_data_t prod_axi_wdata,
  input  wire                     prod_axi_wvalid,
  output wire                     prod_axi_wready,
  output wire                     prod_axi_bvalid,
  input  wire                     prod_axi_bready,

  // consumer
  input  wire axi_pkg::axi_addr_t cons_axi_araddr,
  input  wire                     cons_axi_arvalid,
  output wire                     cons_axi_arready,
  output wire axi_pkg::axi_data_t cons_axi_rdata,
  output wire                     cons_axi_rvalid,
  input  wire                     cons_axi_rready,

  // sram0 pins
  output wire axi_pkg::axi_addr_t sram0_io_addr,
  inout  wire axi_pkg::axi_data_t sram0_io_data,
  output wire                     sram0_io_we_n,
  output wire                     sram0_io_oe_n,
  output wire                     sram0_io_ce_n,

  // sram1 pins
  output wire axi_pkg::axi_addr_t sram1_io_addr,
  inout  wire axi_pkg::axi_data_t sram1_io_data,
  output wire                     sram1_io_we_n,
  output wire                     sram1_io_oe_n,
  output wire                     sram1_io_ce_n
);

  // router to controller 0
  wire axi_pkg::axi_addr_t s0_awaddr;
  wire                     s0_awvalid;
  wire                     s0_awready;
  wire axi_pkg::axi_data_t s0_wdata;
  wire                     s0_wvalid;
  wire                     s0_wready;
  wire                     s0_bvalid;
  wire                     s0_bready;
  wire axi_pkg::axi_addr_t s0_araddr;
  wire                     s0_arvalid;
  wire                     s0_arready;
  wire axi_pkg::axi_data_t s0_rdata;
  wire                     s0_rvalid;
  wire                     s0_rready;

  // router to controller 1
  wire axi_pkg::axi_addr_t s1_awaddr;
  wire                     s1_awvalid;
  wire                     s1_awready;
  wire axi_pkg::axi_data_t s1_wdata;
  wire                     s1_wvalid;
  wire                     s1_wready;
  wire                     s1_bvalid;
  wire                     s1_bready;
  wire axi_pkg::axi_addr_t s1_araddr;
  wire                     s1_arvalid;
  wire                     s1_arready;
  wire axi_pkg::axi_data_t s1_rdata;
  wire                     s1_rvalid;
  wire                     s1_rready;

  axi_2x2 dbuf (
    .clk         (clk),
    .reset       (reset),
    .switch      (switch),
    .sel         (prod_bank),
    .awaddr      (prod_axi_awaddr),
    .awvalid     (prod_axi_awvalid),
    .awready     (prod_axi_awready),
    .wdata       (prod_axi_wdata),
    .wvalid      (prod_axi_wvalid),
    .wready      (prod_axi_wready),
    .bvalid      (prod_axi_bvalid),
    .bready      (prod_axi_bready),
    .araddr      (cons_axi_araddr),
    .arvalid     (cons_axi_arvalid),
    .arready     (cons_axi_arready),
    .rdata       (cons_axi_rdata),
    .rvalid      (cons_axi_rvalid),
    .rready      (cons_axi_rready),
    .out0_awaddr (s0_awaddr),
    .out0_awvalid(s0_awvalid),
    .out0_awready(s0_awready),
    .out0_wdata  (s0_wdata),
    .out0_wvalid (s0_wvalid),
    .out0_wready (s0_wready),
    .out0_bvalid (s0_bvalid),
    .out0_bready (s0_bready),
    .out0_araddr (s0_araddr),
    .out0_arvalid(s0_arvalid),
    .out0_arready(s0_arready),
    .out0_rdata  (s0_rdata),
    .out0_rvalid (s0_rvalid),
    .out0_rready (s0_rready),
    .out1_awaddr (s1_awaddr),
    .out1_awvalid(s1_awvalid),
    .out1_awready(s1_awready),
    .out1_wdata  (s1_wdata),
    .out1_wvalid (s1_wvalid),
    .out1_wready (s1_wready),
    .out1_bvalid (s1_bvalid),
    .out1_bready (s1_bready),
    .out1_araddr (s1_araddr),
    .out1_arvalid(s1_arvalid),
    .out1_arready(s1_arready),
    .out1_rdata  (s1_rdata),
    .out1_rvalid (s1_rvalid),
    .out1_rready (s1_rready)
  );

  axi_sram_controller ctrl_0 (
    .clk         (clk),
    .reset       (reset),
    .awaddr      (s0_awaddr),
    .awvalid     (s0_awvalid),
    .awready     (s0_awready),
    .wdata       (s0_wdata),
    .wvalid      (s0_wvalid),
    .wready      (s0_wready),
    .bvalid      (s0_bvalid),
    .bready      (s0_bready),
    .araddr      (s0_araddr),
    .arvalid     (s0_arvalid),
    .arready     (s0_arready),
    .rdata       (s0_rdata),
    .rvalid      (s0_rvalid),
    .rready      (s0_rready),
    .sram_io_addr(sram0_io_addr),
    .sram_io_data(sram0_io_data),
    .sram_io_we_n(sram0_io_we_n),
    .sram_io_oe_n(sram0_io_oe_n),
    .sram_io_ce_n(sram0_io_ce_n)
  );

  axi_sram_controller ctrl_1 (
    .clk         (clk),
    .reset       (reset),
    .awaddr      (s1_awaddr),
    .awvalid     (s1_awvalid),
    .awready     (s1_awready),
    .wdata       (s1_wdata),
    .wvalid      (s1_wvalid),
    .wready      (s1_wready),
    .bvalid      (s1_bvalid),
    .bready      (s1_bready),
    .araddr      (s1_araddr),
    .arvalid     (s1_arvalid),
    .arready     (s1_arready),
    .rdata       (s1_rdata),
    .rvalid      (s1_rvalid),
    .rready      (s1_rready),
    .sram_io_addr(sram1_io_addr),
    .sram_io_data(sram1_io_data),
    .sram_io_we_n(sram1_io_we_n),
    .sram_io_oe_n(sram1_io_oe_n),
    .sram_io_ce_n(sram1_io_ce_n)
  );

endmodule

`default_nettype wire

//--- rtl/sram_pkg.sv
`default_nettype none

package sram_pkg;

  // which of the two SRAM banks, 0 or 1
  typedef logic [0:0] bank_t;

  // one pin cycle per access, then wait for the response handshake
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WRITE_RESP,
    READ,
    READ_RESP
  } sram_state_e;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary -f tb.f --top-module axi_sram_dbuf_controller_tb -Mdir obj_dir \
  -o tb_sim > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 && echo "simulator exited normally" >> sim.log \
  || echo "simulator exited with an error status" >> sim.log
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

//--- tb.f
rtl/axi_pkg.sv
rtl/sram_pkg.sv
rtl/axi_sram_controller.sv
rtl/axi_2x2.sv
rtl/axi_sram_dbuf_controller.sv
verification/sram_model.sv
verification/axi_sram_dbuf_controller_tb.sv

//--- verification/axi_sram_dbuf_controller_tb.sv
`default_nettype none

module axi_sram_dbuf_controller_tb;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_SWAP, OP_WRITE_SWAP} op_e;

  // target is the bank the entry is expected to touch, or the producer bank after a swap
  typedef struct packed {
    op_e                kind;
    axi_pkg::axi_addr_t addr;
    sram_pkg::bank_t    target;
  } entry_t;

  localparam int NUM_ENTRIES  = 15;
  localparam int RESET_CYCLES = 16;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 30 * NUM_ENTRIES;

  logic clk;
  logic reset;
  logic switch;
  logic prod_axi_awvalid;
  logic prod_axi_wvalid;
  logic prod_axi_bready;
  logic cons_axi_arvalid;
  logic cons_axi_rready;
  axi_pkg::axi_addr_t prod_axi_awaddr;
  axi_pkg::axi_data_t prod_axi_wdata;
  axi_pkg::axi_addr_t cons_axi_araddr;

  wire sram_pkg::bank_t    prod_bank;
  wire                     prod_axi_awready;
  wire                     prod_axi_wready;
  wire                     prod_axi_bvalid;
  wire                     cons_axi_arready;
  wire axi_pkg::axi_data_t cons_axi_rdata;
  wire                     cons_axi_rvalid;
  wire axi_pkg::axi_addr_t sram0_addr;
  wire axi_pkg::axi_data_t sram0_data;
  wire                     sram0_we_n;
  wire                     sram0_oe_n;
  wire                     sram0_ce_n;
  wire axi_pkg::axi_addr_t sram1_addr;
  wire axi_pkg::axi_data_t sram1_data;
  wire                     sram1_we_n;
  wire                     sram1_oe_n;
  wire                     sram1_ce_n;

  entry_t stim [NUM_ENTRIES] = '{
    '{OP_WRITE,      20'h00010, 1'b0},
    '{OP_WRITE,      20'h00011, 1'b0},
    '{OP_WRITE,      20'hfffff, 1'b0},
    '{OP_READ,       20'h00010, 1'b1},
    '{OP_SWAP,       20'h00000, 1'b1},
    '{OP_READ,       20'h00010, 1'b0},
    '{OP_READ,       20'hfffff, 1'b0},
    '{OP_WRITE,      20'h00010, 1'b1},
    '{OP_READ,       20'h00011, 1'b0},
    '{OP_READ,       20'h00010, 1'b0},
    '{OP_WRITE_SWAP, 20'h00020, 1'b1},
    '{OP_READ,       20'h00010, 1'b1},
    '{OP_READ,       20'h00020, 1'b1},
    '{OP_WRITE,      20'h00010, 1'b0},
    '{OP_READ,       20'h00030, 1'b1}
  };

  // reference contents of each bank
  axi_pkg::axi_data_t ref0 [axi_pkg::axi_addr_t];
  axi_pkg::axi_data_t ref1 [axi_pkg::axi_addr_t];
  sram_pkg::bank_t    model_bank;
  int                 cycles = 0;

  axi_sram_dbuf_controller i_dut (
    .clk             (clk),
    .reset           (reset),
    .switch          (switch),
    .prod_bank       (prod_bank),
    .prod_axi_awaddr (prod_axi_awaddr),
    .prod_axi_awvalid(prod_axi_awvalid),
    .prod_axi_awready(prod_axi_awready),
    .prod_axi_wdata  (prod_axi_wdata),
    .prod_axi_wvalid (prod_axi_wvalid),
    .prod_axi_wready (prod_axi_wready),
    .prod_axi_bvalid (prod_axi_bvalid),
    .prod_axi_bready (prod_axi_bready),
    .cons_axi_araddr (cons_axi_araddr),
    .cons_axi_arvalid(cons_axi_arvalid),
    .cons_axi_arready(cons_axi_arready),
    .cons_axi_rdata  (cons_axi_rdata),
    .cons_axi_rvalid (cons_axi_rvalid),
    .cons_axi_rready (cons_axi_rready),
    .sram0_io_addr   (sram0_addr),
    .sram0_io_data   (sram0_data),
    .sram0_io_we_n   (sram0_we_n),
    .sram0_io_oe_n   (sram0_oe_n),
    .sram0_io_ce_n   (sram0_ce_n),
    .sram1_io_addr   (sram1_addr),
    .sram1_io_data   (sram1_data),
    .sram1_io_we_n   (sram1_we_n),
    .sram1_io_oe_n   (sram1_oe_n),
    .sram1_io_ce_n   (sram1_ce_n)
  );

  sram_model i_sram0 (
    .addr(sram0_addr),
    .data(sram0_data),
    .we_n(sram0_we_n),
    .oe_n(sram0_oe_n),
    .ce_n(sram0_ce_n)
  );

  sram_model i_sram1 (
    .addr(sram1_addr),
    .data(sram1_data),
    .we_n(sram1_we_n),
    .oe_n(sram1_oe_n),
    .ce_n(sram1_ce_n)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, the stimulus table did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual) else begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at the first error");
    end
  endtask

  // unwritten locations read as zero
  function automatic axi_pkg::axi_data_t ref_read(input sram_pkg::bank_t bank,
                                                  input axi_pkg::axi_addr_t addr);
    if (bank == 1'b0) begin
      return ref0.exists(addr) ? ref0[addr] : '0;
    end
    return ref1.exists(addr) ? ref1[addr] : '0;
  endfunction

  function automatic axi_pkg::axi_data_t chip_word(input sram_pkg::bank_t bank,
                                                   input axi_pkg::axi_addr_t addr);
    return bank ? i_sram1.mem[addr] : i_sram0.mem[addr];
  endfunction

  task automatic wait_for_swap(input string name, input sram_pkg::bank_t old_bank);
    do @(posedge clk); while (prod_bank == old_bank);
    model_bank = ~model_bank;
    check_value({name, " bank after swap"}, 32'(model_bank), 32'(prod_bank));
    // one toggle only
    repeat (4) begin
      @(posedge clk);
      check_value({name, " bank held"}, 32'(model_bank), 32'(prod_bank));
    end
  endtask

  task automatic write_word(input string name, input axi_pkg::axi_addr_t addr,
                            input bit swap_during);
    axi_pkg::axi_data_t data;
    sram_pkg::bank_t    bank;
    int                 lat;
    int                 stall;
    data  = axi_pkg::axi_data_t'($urandom);
    stall = int'($urandom_range(3, 0));
    bank  = model_bank;
    prod_axi_awaddr  <= addr;
    prod_axi_awvalid <= 1'b1;
    prod_axi_wdata   <= data;
    prod_axi_wvalid  <= 1'b1;
    do @(posedge clk); while (!(prod_axi_awready && prod_axi_wready));
    prod_axi_awvalid <= 1'b0;
    prod_axi_wvalid  <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!prod_axi_bvalid);
    check_value({name, " bvalid latency"}, 32'(2), 32'(lat));
    check_value({name, " producer chip"}, 32'(data), 32'(chip_word(bank, addr)));
    check_value({name, " consumer chip"}, 32'(ref_read(~bank, addr)),
                32'(chip_word(~bank, addr)));
    if (bank == 1'b0) begin
      ref0[addr] = data;
    end else begin
      ref1[addr] = data;
    end
    if (swap_during) begin
      switch <= 1'b1;
      @(posedge clk);
      switch <= 1'b0;
      check_value({name, " bvalid held"}, 32'(1), 32'(prod_axi_bvalid));
    end
    // response stalled, a second request waits on the bus and must not be taken
    prod_axi_awvalid <= 1'b1;
    prod_axi_wvalid  <= 1'b1;
    repeat (stall) begin
      @(posedge clk);
      check_value({name, " bvalid held"}, 32'(1), 32'(prod_axi_bvalid));
      check_value({name, " awready while stalled"}, 32'(0), 32'(prod_axi_awready));
      check_value({name, " bank while stalled"}, 32'(bank), 32'(prod_bank));
    end
    prod_axi_awvalid <= 1'b0;
    prod_axi_wvalid  <= 1'b0;
    prod_axi_bready  <= 1'b1;
    @(posedge clk);
    check_value({name, " bank at response"}, 32'(bank), 32'(prod_bank));
    prod_axi_bready <= 1'b0;
    if (swap_during) begin
      wait_for_swap(name, bank);
    end
  endtask

  task automatic read_word(input string name, input axi_pkg::axi_addr_t addr);
    axi_pkg::axi_data_t expected;
    int                 lat;
    int                 stall;
    expected = ref_read(~model_bank, addr);
    stall    = int'($urandom_range(3, 0));
    cons_axi_araddr  <= addr;
    cons_axi_arvalid <= 1'b1;
    do @(posedge clk); while (!cons_axi_arready);
    cons_axi_arvalid <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
    end while (!cons_axi_rvalid);
    check_value({name, " rvalid latency"}, 32'(2), 32'(lat));
    check_value({name, " rdata"}, 32'(expected), 32'(cons_axi_rdata));
    // a second read request waits while the data is stalled
    cons_axi_arvalid <= 1'b1;
    repeat (stall) begin
      @(posedge clk);
      check_value({name, " rvalid held"}, 32'(1), 32'(cons_axi_rvalid));
      check_value({name, " rdata held"}, 32'(expected), 32'(cons_axi_rdata));
      check_value({name, " arready while stalled"}, 32'(0), 32'(cons_axi_arready));
    end
    cons_axi_arvalid <= 1'b0;
    cons_axi_rready  <= 1'b1;
    @(posedge clk);
    cons_axi_rready <= 1'b0;
  endtask

  initial begin
    op_e   kind;
    string name;
    void'($urandom(32'he1c09ce2));
    clk              = 1'b0;
    reset            = 1'b1;
    switch           = 1'b0;
    prod_axi_awaddr  = '0;
    prod_axi_awvalid = 1'b0;
    prod_axi_wdata   = '0;
    prod_axi_wvalid  = 1'b0;
    prod_axi_bready  = 1'b0;
    cons_axi_araddr  = '0;
    cons_axi_arvalid = 1'b0;
    cons_axi_rready  = 1'b0;
    model_bank       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    check_value("reset handshakes", 32'h0, 32'({prod_axi_awready, prod_axi_wready,
                cons_axi_arready, prod_axi_bvalid, cons_axi_rvalid}));
    check_value("reset strobes", 32'h3f, 32'({sram0_ce_n, sram0_we_n, sram0_oe_n,
                sram1_ce_n, sram1_we_n, sram1_oe_n}));
    check_value("reset prod_bank", 32'h0, 32'(prod_bank));
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      kind = stim[i].kind;
      name = $sformatf("entry %0d %s", i, kind.name());
      if (kind == OP_READ) begin
        check_value({name, " consumer bank"}, 32'(stim[i].target), 32'(!prod_bank));
        read_word(name, stim[i].addr);
      end else if (kind == OP_SWAP) begin
        switch <= 1'b1;
        @(posedge clk);
        switch <= 1'b0;
        wait_for_swap(name, model_bank);
        check_value({name, " target bank"}, 32'(stim[i].target), 32'(prod_bank));
      end else begin
        check_value({name, " producer bank"}, 32'(stim[i].target), 32'(prod_bank));
        write_word(name, stim[i].addr, kind == OP_WRITE_SWAP);
      end
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/sram_model.sv
`default_nettype none

// asynchronous SRAM, one word per address
module sram_model (
  input  wire axi_pkg::axi_addr_t addr,
  inout  wire axi_pkg::axi_data_t data,
  input  wire                     we_n,
  input  wire                     oe_n,
  input  wire                     ce_n
);

  localparam int DEPTH = 1 << axi_pkg::AXI_ADDR_WIDTH;

  axi_pkg::axi_data_t mem [0:DEPTH-1];

  // powers up as all zeros
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[axi_pkg::axi_addr_t'(i)] = '0;
    end
  end

  // output enable drives the pins, never during a write
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

  // address and data settle with the strobe, so take the word a little later
  always @(negedge we_n) begin
    #1;
    if (!ce_n) begin
      mem[addr] = data;
    end
  end

endmodule

`default_nettype wire
